// ==== hdl/pet_display_macros.svh ====
`ifndef PET_DISPLAY_MACROS_SVH
`define PET_DISPLAY_MACROS_SVH

// Page geometry.
`define PAGE_BYTES      1024
`define BYTE_INDEX_W    10
`define SPRITE_ADDR_W   15
`define SPRITE_FRAMES   30

// Frames per mood.
`define IDLE_FRAMES     6
`define SLEEP_FRAMES    4
`define EAT_FRAMES      5
`define TEACH_FRAMES    7
`define DEAD_FRAMES     8

// First frame number of each mood.
`define IDLE_BASE       0
`define SLEEP_BASE      6
`define EAT_BASE        10
`define TEACH_BASE      15
`define DEAD_BASE       22

// Meter layout.
`define BYTES_PER_ROW   8
`define METER_ROWS      5
`define HAPPY_ROW       8
`define HUNGER_ROW      18
`define SLEEP_ROW       28
`define METER_FULL      8'hEE
`define METER_HALF      8'hE0

`define FIFO_DEPTH      4
`define PAGES_PER_STEP  2

`endif

// ==== hdl/pet_display_pkg.sv ====
`include "pet_display_macros.svh"

package pet_display_pkg;

    typedef logic [7:0] level_t;                       // Status level.
    typedef logic [7:0] pixel_byte_t;                  // Eight vertical pixels.
    typedef logic [`BYTE_INDEX_W-1:0] byte_index_t;
    typedef logic [`SPRITE_ADDR_W-1:0] sprite_addr_t;
    typedef logic [2:0] frame_idx_t;                   // Frame within one mood.

    // One-hot mood codes, zero is idle.
    typedef enum logic [3:0] {
        MOOD_IDLE     = 4'd0,
        MOOD_SLEEPING = 4'd1,
        MOOD_EATING   = 4'd2,
        MOOD_TEACHING = 4'd4,
        MOOD_DEAD     = 4'd8
    } mood_t;

    typedef enum logic [1:0] {
        RENDER_IDLE,
        RENDER_RUN,
        RENDER_WAIT_DONE,
        RENDER_WAIT_RELEASE
    } render_state_t;

    typedef enum logic [1:0] {
        LINK_IDLE,
        LINK_REQUEST,
        LINK_RELEASE
    } link_state_t;

endpackage

// ==== hdl/status_meter.sv ====
`timescale 1ns/1ns
`include "pet_display_macros.svh"

module status_meter (
    input  pet_display_pkg::byte_index_t i_index,
    input  pet_display_pkg::level_t      i_happiness,
    input  pet_display_pkg::level_t      i_hunger,
    input  pet_display_pkg::level_t      i_sleepiness,
    output logic                         o_hit,
    output pet_display_pkg::pixel_byte_t o_meter_byte
);

    localparam int COL_W = $clog2(`BYTES_PER_ROW);
    localparam int ROW_W = `BYTE_INDEX_W - COL_W;

    logic [ROW_W-1:0] row;
    logic [COL_W-1:0] col;
    logic in_happy;
    logic in_hunger;
    logic in_sleep;
    logic col_hit;
    pet_display_pkg::level_t level;
    int full_thr;
    int half_thr;

    function automatic logic in_band(input logic [ROW_W-1:0] r, input int first);
        return (int'(r) >= first) && (int'(r) < first + `METER_ROWS);
    endfunction

    assign row = ROW_W'(i_index / `BYTES_PER_ROW);
    assign col = COL_W'(i_index % `BYTES_PER_ROW);

    assign in_happy  = in_band(row, `HAPPY_ROW);
    assign in_hunger = in_band(row, `HUNGER_ROW);
    assign in_sleep  = in_band(row, `SLEEP_ROW);
    assign col_hit   = (col >= COL_W'(1)) && (col <= COL_W'(5));   // Five bar steps.
    assign o_hit     = col_hit && (in_happy || in_hunger || in_sleep);

    assign level = in_happy ? i_happiness : (in_hunger ? i_hunger : i_sleepiness);

    // Column 1 needs the most, column 5 the least.
    assign full_thr = 110 - 20 * int'(col);
    assign half_thr = 100 - 20 * int'(col);

    always_comb begin
        if (!o_hit)
            o_meter_byte = '0;
        else if (int'(level) > full_thr)
            o_meter_byte = `METER_FULL;
        else if (int'(level) > half_thr)
            o_meter_byte = `METER_HALF;
        else
            o_meter_byte = '0;
    end

endmodule

// ==== hdl/sprite_memory.sv ====
`timescale 1ns/1ns
`include "pet_display_macros.svh"

module sprite_memory (
    input  logic                          clk,
    input  logic                          i_wr_en,
    input  pet_display_pkg::sprite_addr_t i_wr_addr,
    input  pet_display_pkg::pixel_byte_t  i_wr_data,
    input  pet_display_pkg::sprite_addr_t i_rd_addr,
    output pet_display_pkg::pixel_byte_t  o_rd_data
);

    localparam int DEPTH = `SPRITE_FRAMES * `PAGE_BYTES;

    // All frames back to back, one page per frame.
    pet_display_pkg::pixel_byte_t mem [DEPTH];

    always_ff @(posedge clk) begin
        if (i_wr_en)
            mem[i_wr_addr] <= i_wr_data;
        o_rd_data <= mem[i_rd_addr];        // One cycle read.
    end

endmodule

// ==== hdl/byte_fifo.sv ====
`timescale 1ns/1ns
`include "pet_display_macros.svh"

module byte_fifo #(
    parameter int DEPTH = `FIFO_DEPTH
) (
    input  logic                         clk,
    input  logic                         i_reset,
    input  logic                         i_push,
    input  pet_display_pkg::pixel_byte_t i_push_data,
    input  logic                         i_push_last,
    output logic                         o_full,
    input  logic                         i_pop,
    output pet_display_pkg::pixel_byte_t o_pop_data,
    output logic                         o_pop_last,
    output logic                         o_empty
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    pet_display_pkg::pixel_byte_t data_mem [DEPTH];
    logic                         last_mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic do_push;
    logic do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (int'(ptr) == DEPTH - 1)
            return '0;
        return ptr + PTR_W'(1);
    endfunction

    assign o_full     = (count == CNT_W'(DEPTH));
    assign o_empty    = (count == '0);
    assign do_push    = i_push && !o_full;      // Ignored when full.
    assign do_pop     = i_pop && !o_empty;
    assign o_pop_data = data_mem[rd_ptr];
    assign o_pop_last = last_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (i_reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= next_ptr(wr_ptr);
            if (do_pop)
                rd_ptr <= next_ptr(rd_ptr);
            case ({do_push, do_pop})
                2'b10:   count <= count + CNT_W'(1);
                2'b01:   count <= count - CNT_W'(1);
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            data_mem[wr_ptr] <= i_push_data;
            last_mem[wr_ptr] <= i_push_last;
        end
    end

endmodule

// ==== hdl/link_transmitter.sv ====
`timescale 1ns/1ns

module link_transmitter (
    input  logic                         clk,
    input  logic                         i_reset,
    input  logic                         i_empty,
    output logic                         o_pop,
    input  pet_display_pkg::pixel_byte_t i_pop_data,
    input  logic                         i_pop_last,
    output logic                         o_link_req,
    input  logic                         i_link_ack,
    output pet_display_pkg::pixel_byte_t o_link_data,
    output logic                         o_page_done
);

    pet_display_pkg::link_state_t state;
    logic last_q;

    // A new byte only starts once the display has dropped its ack.
    assign o_pop = (state == pet_display_pkg::LINK_IDLE) && !i_empty && !i_link_ack;

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state       <= pet_display_pkg::LINK_IDLE;
            o_link_req  <= 1'b0;
            o_page_done <= 1'b0;
        end else begin
            o_page_done <= 1'b0;
            case (state)
                pet_display_pkg::LINK_IDLE: begin
                    if (o_pop) begin
                        o_link_req <= 1'b1;     // Data valid with req.
                        state      <= pet_display_pkg::LINK_REQUEST;
                    end
                end
                pet_display_pkg::LINK_REQUEST: begin
                    if (i_link_ack) begin
                        o_link_req <= 1'b0;
                        state      <= pet_display_pkg::LINK_RELEASE;
                    end
                end
                default: begin
                    if (!i_link_ack) begin
                        o_page_done <= last_q;  // End of page.
                        state       <= pet_display_pkg::LINK_IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (o_pop) begin
            o_link_data <= i_pop_data;
            last_q      <= i_pop_last;
        end
    end

endmodule

// ==== hdl/page_renderer.sv ====
`timescale 1ns/1ns
`include "pet_display_macros.svh"

module page_renderer (
    input  logic                          clk,
    input  logic                          i_reset,
    input  logic                          i_refresh_req,
    output logic                          o_refresh_ack,
    input  pet_display_pkg::mood_t        i_mood,
    input  pet_display_pkg::level_t       i_happiness,
    input  pet_display_pkg::level_t       i_hunger,
    input  pet_display_pkg::level_t       i_sleepiness,
    output pet_display_pkg::sprite_addr_t o_rd_addr,
    input  pet_display_pkg::pixel_byte_t  i_rd_data,
    input  logic                          i_fifo_full,
    output logic                          o_push,
    output pet_display_pkg::pixel_byte_t  o_push_data,
    output logic                          o_push_last,
    input  logic                          i_page_done
);

    localparam int FRAME_NUM_W = `SPRITE_ADDR_W - `BYTE_INDEX_W;
    localparam pet_display_pkg::byte_index_t LAST_INDEX =
        pet_display_pkg::byte_index_t'(`PAGE_BYTES - 1);

    pet_display_pkg::render_state_t state;
    pet_display_pkg::mood_t         mood_q;
    pet_display_pkg::level_t        happiness_q;
    pet_display_pkg::level_t        hunger_q;
    pet_display_pkg::level_t        sleepiness_q;
    pet_display_pkg::frame_idx_t    idle_frame;
    pet_display_pkg::frame_idx_t    sleep_frame;
    pet_display_pkg::frame_idx_t    eat_frame;
    pet_display_pkg::frame_idx_t    teach_frame;
    pet_display_pkg::frame_idx_t    dead_frame;
    pet_display_pkg::byte_index_t   walk_index;
    pet_display_pkg::byte_index_t   merge_index;
    pet_display_pkg::byte_index_t   rd_index;
    pet_display_pkg::pixel_byte_t   meter_byte;
    logic [7:0]             step_count;
    logic [FRAME_NUM_W-1:0] frame_num;
    logic walk_valid;
    logic merge_valid;
    logic advance;
    logic mood_valid;
    logic meter_hit;

    function automatic pet_display_pkg::frame_idx_t next_frame(
        input pet_display_pkg::frame_idx_t frame,
        input int                          count
    );
        if (int'(frame) == count - 1)
            return '0;
        return frame + 3'd1;
    endfunction

    // Frame number of the latched mood.
    always_comb begin
        mood_valid = 1'b1;
        case (mood_q)
            pet_display_pkg::MOOD_IDLE:
                frame_num = FRAME_NUM_W'(`IDLE_BASE) + FRAME_NUM_W'(idle_frame);
            pet_display_pkg::MOOD_SLEEPING:
                frame_num = FRAME_NUM_W'(`SLEEP_BASE) + FRAME_NUM_W'(sleep_frame);
            pet_display_pkg::MOOD_EATING:
                frame_num = FRAME_NUM_W'(`EAT_BASE) + FRAME_NUM_W'(eat_frame);
            pet_display_pkg::MOOD_TEACHING:
                frame_num = FRAME_NUM_W'(`TEACH_BASE) + FRAME_NUM_W'(teach_frame);
            pet_display_pkg::MOOD_DEAD:
                frame_num = FRAME_NUM_W'(`DEAD_BASE) + FRAME_NUM_W'(dead_frame);
            default: begin
                frame_num  = '0;
                mood_valid = 1'b0;              // Blank sprite.
            end
        endcase
    end

    // On a stall the held byte is read again so the RAM output stays put.
    assign advance     = !merge_valid || !i_fifo_full;
    assign rd_index    = advance ? walk_index : merge_index;
    assign o_rd_addr   = {frame_num, rd_index};
    assign o_push      = merge_valid && !i_fifo_full;
    assign o_push_last = (merge_index == LAST_INDEX);
    assign o_push_data = meter_hit ? meter_byte : (mood_valid ? i_rd_data : '0);

    status_meter status_meter_inst (
        .i_index      (merge_index),
        .i_happiness  (happiness_q),
        .i_hunger     (hunger_q),
        .i_sleepiness (sleepiness_q),
        .o_hit        (meter_hit),
        .o_meter_byte (meter_byte)
    );

    always_ff @(posedge clk) begin
        if (i_reset) begin
            state         <= pet_display_pkg::RENDER_IDLE;
            o_refresh_ack <= 1'b0;
            mood_q        <= pet_display_pkg::MOOD_IDLE;
            walk_index    <= '0;
            walk_valid    <= 1'b0;
            merge_valid   <= 1'b0;
            step_count    <= '0;
            idle_frame    <= '0;
            sleep_frame   <= '0;
            eat_frame     <= '0;
            teach_frame   <= '0;
            dead_frame    <= '0;
        end else begin
            if (advance) begin
                merge_valid <= walk_valid;
                if (walk_valid) begin
                    if (walk_index == LAST_INDEX)
                        walk_valid <= 1'b0;      // Whole page issued.
                    else
                        walk_index <= walk_index + 1'b1;
                end
            end
            case (state)
                pet_display_pkg::RENDER_IDLE: begin
                    if (i_refresh_req) begin
                        mood_q     <= i_mood;
                        walk_index <= '0;
                        walk_valid <= 1'b1;
                        state      <= pet_display_pkg::RENDER_RUN;
                    end
                end
                pet_display_pkg::RENDER_RUN: begin
                    if (o_push && o_push_last)
                        state <= pet_display_pkg::RENDER_WAIT_DONE;
                end
                pet_display_pkg::RENDER_WAIT_DONE: begin
                    if (i_page_done) begin
                        o_refresh_ack <= 1'b1;
                        state         <= pet_display_pkg::RENDER_WAIT_RELEASE;
                    end
                end
                default: begin
                    if (!i_refresh_req) begin
                        o_refresh_ack <= 1'b0;
                        state         <= pet_display_pkg::RENDER_IDLE;
                        if (step_count == 8'(`PAGES_PER_STEP - 1)) begin
                            step_count  <= '0;
                            idle_frame  <= next_frame(idle_frame, `IDLE_FRAMES);
                            sleep_frame <= next_frame(sleep_frame, `SLEEP_FRAMES);
                            eat_frame   <= next_frame(eat_frame, `EAT_FRAMES);
                            teach_frame <= next_frame(teach_frame, `TEACH_FRAMES);
                            dead_frame  <= next_frame(dead_frame, `DEAD_FRAMES);
                        end else begin
                            step_count <= step_count + 8'd1;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == pet_display_pkg::RENDER_IDLE && i_refresh_req) begin
            happiness_q  <= i_happiness;            // Held for the page.
            hunger_q     <= i_hunger;
            sleepiness_q <= i_sleepiness;
        end
        if (advance)
            merge_index <= walk_index;
    end

endmodule

// ==== hdl/pet_display_top.sv ====
`timescale 1ns/1ns

module pet_display_top (
    input  logic                          clk,
    input  logic                          i_reset,
    input  logic                          i_refresh_req,
    output logic                          o_refresh_ack,
    input  pet_display_pkg::mood_t        i_mood,
    input  pet_display_pkg::level_t       i_happiness,
    input  pet_display_pkg::level_t       i_hunger,
    input  pet_display_pkg::level_t       i_sleepiness,
    input  logic                          i_wr_en,
    input  pet_display_pkg::sprite_addr_t i_wr_addr,
    input  pet_display_pkg::pixel_byte_t  i_wr_data,
    output logic                          o_link_req,
    input  logic                          i_link_ack,
    output pet_display_pkg::pixel_byte_t  o_link_data
);

    pet_display_pkg::sprite_addr_t rd_addr;
    pet_display_pkg::pixel_byte_t  rd_data;
    pet_display_pkg::pixel_byte_t  push_data;
    pet_display_pkg::pixel_byte_t  pop_data;
    logic fifo_full;
    logic fifo_empty;
    logic push;
    logic push_last;
    logic pop;
    logic pop_last;
    logic page_done;

    page_renderer page_renderer_inst (
        .clk           (clk),
        .i_reset       (i_reset),
        .i_refresh_req (i_refresh_req),
        .o_refresh_ack (o_refresh_ack),
        .i_mood        (i_mood),
        .i_happiness   (i_happiness),
        .i_hunger      (i_hunger),
        .i_sleepiness  (i_sleepiness),
        .o_rd_addr     (rd_addr),
        .i_rd_data     (rd_data),
        .i_fifo_full   (fifo_full),
        .o_push        (push),
        .o_push_data   (push_data),
        .o_push_last   (push_last),
        .i_page_done   (page_done)
    );

    sprite_memory sprite_memory_inst (
        .clk       (clk),
        .i_wr_en   (i_wr_en),
        .i_wr_addr (i_wr_addr),
        .i_wr_data (i_wr_data),
        .i_rd_addr (rd_addr),
        .o_rd_data (rd_data)
    );

    byte_fifo byte_fifo_inst (
        .clk         (clk),
        .i_reset     (i_reset),
        .i_push      (push),
        .i_push_data (push_data),
        .i_push_last (push_last),
        .o_full      (fifo_full),
        .i_pop       (pop),
        .o_pop_data  (pop_data),
        .o_pop_last  (pop_last),
        .o_empty     (fifo_empty)
    );

    link_transmitter link_transmitter_inst (
        .clk         (clk),
        .i_reset     (i_reset),
        .i_empty     (fifo_empty),
        .o_pop       (pop),
        .i_pop_data  (pop_data),
        .i_pop_last  (pop_last),
        .o_link_req  (o_link_req),
        .i_link_ack  (i_link_ack),
        .o_link_data (o_link_data),
        .o_page_done (page_done)
    );

endmodule

// ==== bench/pet_display_properties.sv ====
`timescale 1ns/1ns

module pet_display_properties (
    input logic                         clk,
    input logic                         i_reset,
    input logic                         i_refresh_req,
    input logic                         o_refresh_ack,
    input logic                         o_link_req,
    input logic                         i_link_ack,
    input pet_display_pkg::pixel_byte_t o_link_data
);

    // The display keeps seeing the request until it answers.
    link_req_held: assert property (
        @(posedge clk) disable iff (i_reset)
        o_link_req && !i_link_ack |=> o_link_req
    ) else $error("o_link_req dropped before i_link_ack was seen");

    link_data_stable: assert property (
        @(posedge clk) disable iff (i_reset)
        o_link_req ##1 o_link_req |-> $stable(o_link_data)
    ) else $error("o_link_data changed during a link request");

    // A new byte waits for the previous ack to fall.
    link_req_after_release: assert property (
        @(posedge clk) disable iff (i_reset)
        !o_link_req && i_link_ack |=> !o_link_req
    ) else $error("o_link_req rose while i_link_ack was high");

    refresh_ack_needs_req: assert property (
        @(posedge clk) disable iff (i_reset)
        $rose(o_refresh_ack) |-> i_refresh_req
    ) else $error("o_refresh_ack rose without a refresh request");

endmodule

// ==== bench/pet_display_tb.sv ====
`timescale 1ns/1ns
`include "pet_display_macros.svh"

module pet_display_tb;

    localparam int SPRITE_BYTES    = `SPRITE_FRAMES * `PAGE_BYTES;
    localparam int REFRESHES       = 12;
    localparam int LINK_TIMEOUT    = 200;
    localparam int REFRESH_TIMEOUT = 60000;

    logic                          clk;
    logic                          i_reset;
    logic                          i_refresh_req;
    logic                          o_refresh_ack;
    pet_display_pkg::mood_t        i_mood;
    pet_display_pkg::level_t       i_happiness;
    pet_display_pkg::level_t       i_hunger;
    pet_display_pkg::level_t       i_sleepiness;
    logic                          i_wr_en;
    pet_display_pkg::sprite_addr_t i_wr_addr;
    pet_display_pkg::pixel_byte_t  i_wr_data;
    logic                          o_link_req;
    logic                          i_link_ack;
    pet_display_pkg::pixel_byte_t  o_link_data;

    pet_display_pkg::pixel_byte_t sprite_copy [SPRITE_BYTES];
    pet_display_pkg::pixel_byte_t got_bytes [$];
    pet_display_pkg::frame_idx_t  model_frame [5];   // Idle, sleep, eat, teach, dead.
    int                           frame_count [5];
    int                           frame_base [5];
    int                           done_refreshes;

    pet_display_top pet_display_top_inst (
        .clk           (clk),
        .i_reset       (i_reset),
        .i_refresh_req (i_refresh_req),
        .o_refresh_ack (o_refresh_ack),
        .i_mood        (i_mood),
        .i_happiness   (i_happiness),
        .i_hunger      (i_hunger),
        .i_sleepiness  (i_sleepiness),
        .i_wr_en       (i_wr_en),
        .i_wr_addr     (i_wr_addr),
        .i_wr_data     (i_wr_data),
        .o_link_req    (o_link_req),
        .i_link_ack    (i_link_ack),
        .o_link_data   (o_link_data)
    );

    bind pet_display_top pet_display_properties pet_display_properties_inst (
        .clk           (clk),
        .i_reset       (i_reset),
        .i_refresh_req (i_refresh_req),
        .o_refresh_ack (o_refresh_ack),
        .o_link_req    (o_link_req),
        .i_link_ack    (i_link_ack),
        .o_link_data   (o_link_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic stop_run();
        $display("Regression failed");
        $fatal(1, "Stopped at the first failure.");
    endtask

    task automatic check_byte(input pet_display_pkg::pixel_byte_t actual,
                              input pet_display_pkg::pixel_byte_t expected,
                              input string what);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns: %s: got 8'h%02h, expected 8'h%02h",
                     $time, what, actual, expected);
            stop_run();
        end
    endtask

    task automatic check_index(input pet_display_pkg::frame_idx_t actual,
                               input pet_display_pkg::frame_idx_t expected,
                               input string what);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns: %s: got frame %0d, expected frame %0d",
                     $time, what, actual, expected);
            stop_run();
        end
    endtask

    task automatic check_flag(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            $display("[ERROR] %0t ns: %s: got %b, expected %b", $time, what, actual, expected);
            stop_run();
        end
    endtask

    task automatic wait_link_req(input logic level);
        int cycles;
        cycles = 0;
        while (o_link_req !== level) begin
            @(posedge clk);
            cycles++;
            if (cycles > LINK_TIMEOUT) begin
                $display("Timeout: o_link_req did not become %b within %0d cycles.",
                         level, LINK_TIMEOUT);
                stop_run();
            end
        end
    endtask

    task automatic wait_refresh_ack(input logic level);
        int cycles;
        cycles = 0;
        while (o_refresh_ack !== level) begin
            @(posedge clk);
            cycles++;
            if (cycles > REFRESH_TIMEOUT) begin
                $display("Timeout: o_refresh_ack did not become %b within %0d cycles.",
                         level, REFRESH_TIMEOUT);
                stop_run();
            end
        end
    endtask

    function automatic int mood_slot(input logic [3:0] code);
        case (code)
            4'd0:    return 0;
            4'd1:    return 1;
            4'd2:    return 2;
            4'd4:    return 3;
            4'd8:    return 4;
            default: return -1;                 // Not a mood.
        endcase
    endfunction

    function automatic logic [3:0] pick_mood(input int number);
        logic [3:0] valid_codes [5];
        logic [3:0] bad_codes [4];
        valid_codes = '{4'd0, 4'd1, 4'd2, 4'd4, 4'd8};
        bad_codes   = '{4'd3, 4'd6, 4'd9, 4'd15};
        if (number == 9)
            return 4'd1;                        // Sleep frames have wrapped.
        if (number == 11)
            return 4'd2;                        // Eat frames have wrapped.
        if (number == 5 || $urandom_range(9, 0) == 0)
            return bad_codes[$urandom_range(3, 0)];
        return valid_codes[$urandom_range(4, 0)];
    endfunction

    function automatic pet_display_pkg::level_t pick_level();
        case ($urandom_range(3, 0))
            0:       return pet_display_pkg::level_t'($urandom_range(11, 0) * 10);
            1:       return ($urandom_range(1, 0) == 1) ? 8'd255 : 8'd0;
            default: return pet_display_pkg::level_t'($urandom);
        endcase
    endfunction

    // Reference byte for one page position.
    function automatic pet_display_pkg::pixel_byte_t expected_byte(
        input int index,
        input int slot,
        input int frame,
        input pet_display_pkg::level_t happy,
        input pet_display_pkg::level_t hunger,
        input pet_display_pkg::level_t sleepy
    );
        int row;
        int col;
        int level;
        row   = index / `BYTES_PER_ROW;
        col   = index % `BYTES_PER_ROW;
        level = -1;
        if (col >= 1 && col <= 5) begin
            if (row >= `HAPPY_ROW && row < `HAPPY_ROW + `METER_ROWS)
                level = int'(happy);
            else if (row >= `HUNGER_ROW && row < `HUNGER_ROW + `METER_ROWS)
                level = int'(hunger);
            else if (row >= `SLEEP_ROW && row < `SLEEP_ROW + `METER_ROWS)
                level = int'(sleepy);
        end
        if (level >= 0) begin
            if (level > 110 - 20 * col)
                return `METER_FULL;
            if (level > 100 - 20 * col)
                return `METER_HALF;
            return 8'h00;
        end
        if (slot < 0)
            return 8'h00;                       // Invalid mood draws nothing.
        return sprite_copy[(frame_base[slot] + frame) * `PAGE_BYTES + index];
    endfunction

    task automatic request_page(input logic [3:0] code,
                                input pet_display_pkg::level_t happy,
                                input pet_display_pkg::level_t hunger,
                                input pet_display_pkg::level_t sleepy);
        @(posedge clk);
        i_mood        <= pet_display_pkg::mood_t'(code);
        i_happiness   <= happy;
        i_hunger      <= hunger;
        i_sleepiness  <= sleepy;
        i_refresh_req <= 1'b1;
        wait_refresh_ack(1'b1);
        check_flag(got_bytes.size() == `PAGE_BYTES, 1'b1,
                   "o_refresh_ack rose before the last link handshake");
        i_refresh_req <= 1'b0;
        repeat (2) @(posedge clk);
        check_flag(o_refresh_ack, 1'b0,
                   "o_refresh_ack did not fall the cycle after i_refresh_req dropped");
    endtask

    // Plays the display side of the link with random ack delays.
    task automatic answer_link();
        pet_display_pkg::pixel_byte_t held;
        int delay;
        repeat (`PAGE_BYTES) begin
            wait_link_req(1'b1);
            held  = o_link_data;
            delay = $urandom_range(5, 0);
            repeat (delay) begin
                @(posedge clk);
                check_byte(o_link_data, held, "o_link_data changed while o_link_req was high");
            end
            i_link_ack <= 1'b1;
            wait_link_req(1'b0);
            delay = $urandom_range(5, 0);
            repeat (delay) @(posedge clk);
            i_link_ack <= 1'b0;
            got_bytes.push_back(held);
        end
    endtask

    task automatic run_refresh(input int number,
                               input logic [3:0] code,
                               input pet_display_pkg::level_t happy,
                               input pet_display_pkg::level_t hunger,
                               input pet_display_pkg::level_t sleepy);
        int slot;
        int frame;
        int found;
        int index;
        int f;
        logic match;
        slot  = mood_slot(code);
        frame = (slot >= 0) ? int'(model_frame[slot]) : 0;
        got_bytes.delete();
        fork
            request_page(code, happy, hunger, sleepy);
            answer_link();
        join
        if (slot >= 0) begin
            found = -1;
            for (f = frame_count[slot] - 1; f >= 0; f--) begin
                match = 1'b1;
                for (index = 0; index < `BYTES_PER_ROW; index++)
                    if (got_bytes[index] !== sprite_copy[(frame_base[slot] + f) * `PAGE_BYTES
                                                         + index])
                        match = 1'b0;
                if (match)
                    found = f;
            end
            if (found < 0) begin
                $display("Page %0d matches no frame of mood code %0d.", number, code);
                stop_run();
            end
            check_index(pet_display_pkg::frame_idx_t'(found), model_frame[slot],
                        $sformatf("page %0d frame index", number));
        end
        for (index = 0; index < `PAGE_BYTES; index++)
            check_byte(got_bytes[index],
                       expected_byte(index, slot, frame, happy, hunger, sleepy),
                       $sformatf("page %0d mood %0d byte %0d", number, code, index));
        done_refreshes++;
        if (done_refreshes % `PAGES_PER_STEP == 0)
            for (f = 0; f < 5; f++)
                model_frame[f] = pet_display_pkg::frame_idx_t'((int'(model_frame[f]) + 1)
                                                               % frame_count[f]);
        repeat (4) begin
            @(posedge clk);
            check_flag(o_link_req, 1'b0, "o_link_req rose after the page ended");
        end
    endtask

    initial begin
        int addr;
        int n;
        logic [3:0] code;
        pet_display_pkg::pixel_byte_t data;
        pet_display_pkg::level_t happy;
        pet_display_pkg::level_t hunger;
        pet_display_pkg::level_t sleepy;
        void'($urandom(32'hd306eaaa));
        i_reset        = 1'b1;
        i_refresh_req  = 1'b0;
        i_mood         = pet_display_pkg::MOOD_IDLE;
        i_happiness    = '0;
        i_hunger       = '0;
        i_sleepiness   = '0;
        i_wr_en        = 1'b0;
        i_wr_addr      = '0;
        i_wr_data      = '0;
        i_link_ack     = 1'b0;
        frame_count    = '{`IDLE_FRAMES, `SLEEP_FRAMES, `EAT_FRAMES, `TEACH_FRAMES, `DEAD_FRAMES};
        frame_base     = '{`IDLE_BASE, `SLEEP_BASE, `EAT_BASE, `TEACH_BASE, `DEAD_BASE};
        model_frame    = '{default: '0};
        done_refreshes = 0;
        repeat (8) @(posedge clk);
        i_reset <= 1'b0;
        // Sprite load; the link must stay quiet meanwhile.
        for (addr = 0; addr < SPRITE_BYTES; addr++) begin
            @(posedge clk);
            data              = pet_display_pkg::pixel_byte_t'($urandom);
            sprite_copy[addr] = data;
            i_wr_en   <= 1'b1;
            i_wr_addr <= pet_display_pkg::sprite_addr_t'(addr);
            i_wr_data <= data;
            check_flag(o_link_req, 1'b0, "o_link_req high before any refresh");
            check_flag(o_refresh_ack, 1'b0, "o_refresh_ack high before any refresh");
        end
        @(posedge clk);
        i_wr_en <= 1'b0;
        for (n = 0; n < REFRESHES; n++) begin
            code   = pick_mood(n);
            happy  = pick_level();
            hunger = pick_level();
            sleepy = pick_level();
            if (n == 0) begin
                happy  = 8'd0;                  // Extremes and an exact threshold.
                hunger = 8'd255;
                sleepy = 8'd90;
            end
            run_refresh(n, code, happy, hunger, sleepy);
        end
        $display("Regression passed");
        $finish;
    end

endmodule

// ==== compile.f ====
+incdir+hdl
hdl/pet_display_pkg.sv
hdl/status_meter.sv
hdl/sprite_memory.sv
hdl/byte_fifo.sv
hdl/link_transmitter.sv
hdl/page_renderer.sv
hdl/pet_display_top.sv
bench/pet_display_properties.sv
bench/pet_display_tb.sv

// ==== Bender.yml ====
package:
  name: pet_display

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/pet_display_pkg.sv
      - hdl/status_meter.sv
      - hdl/sprite_memory.sv
      - hdl/byte_fifo.sv
      - hdl/link_transmitter.sv
      - hdl/page_renderer.sv
      - hdl/pet_display_top.sv
  - target: test
    include_dirs:
      - hdl
    files:
      - bench/pet_display_properties.sv
      - bench/pet_display_tb.sv
